/* common/icache_defs.svh */
`ifndef ICACHE_DEFS_SVH
`define ICACHE_DEFS_SVH

// Cache geometry. The state word is 5 bits per way, so 4 ways give 20 bits.
`define ICACHE_WAYS    4
`define ICACHE_SETS    64

// Address split for a 64-byte line.
`define ICACHE_IDX_W   6
`define ICACHE_OFS_W   6
`define ICACHE_ADDR_W  32
`define ICACHE_TAG_W   (`ICACHE_ADDR_W - `ICACHE_IDX_W - `ICACHE_OFS_W)

// Wishbone classic slave.
`define WB_DAT_W       32

`endif

/* common/icache_pkg.sv */
`include "icache_defs.svh"

package icache_pkg;

    // Line state encoding, as in the reference next-state block.
    typedef enum logic [4:0] {
        ST_INVALID = 5'd0,
        ST_PENDING = 5'd2,
        ST_VALID   = 5'd16
    } line_state_t;

    // Host command, carried in dat_w[1:0] of a write.
    typedef enum logic [1:0] {
        CMD_FETCH = 2'd0,   // f2 load.
        CMD_FILL  = 2'd1,   // L2 write.
        CMD_INV   = 2'd2,   // L2 invalidate.
        CMD_EVICT = 2'd3    // Allocate a victim way.
    } icache_cmd_t;

    // Packed set word, way 3 in bits 19:15 down to way 0 in bits 4:0.
    typedef line_state_t [`ICACHE_WAYS-1:0] set_meta_t;

    // One-hot way select for hit and victim.
    typedef logic [`ICACHE_WAYS-1:0] way_vec_t;

endpackage

/* icache/inext_state.sv */
`timescale 1ns/1ps
`include "icache_defs.svh"

module inext_state (
    input  logic                  valid_in,
    input  icache_pkg::set_meta_t f2_meta_in,
    input  logic                  f2_ld,
    input  logic                  l2_w,
    input  logic                  l2_inv,
    input  logic                  f2_evict,
    input  icache_pkg::way_vec_t  hit_way,
    input  icache_pkg::way_vec_t  evict_way,
    output icache_pkg::set_meta_t next_meta_out
);
    import icache_pkg::*;

    line_state_t cur_state;
    line_state_t next_state;

    // State of the hit way.
    always_comb begin
        cur_state = ST_INVALID;
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            if (hit_way[w]) begin
                cur_state = f2_meta_in[w];
            end
        end
    end

    always_comb begin
        case (cur_state)
            ST_INVALID: next_state = f2_ld ? ST_PENDING : cur_state;
            ST_PENDING: next_state = l2_w ? ST_VALID : cur_state;
            default:    next_state = cur_state;   // Valid holds.
        endcase
    end

    // Replace only the targeted field.
    always_comb begin
        next_meta_out = f2_meta_in;
        if (valid_in) begin
            if (f2_evict) begin
                if ($onehot(evict_way)) begin
                    for (int w = 0; w < `ICACHE_WAYS; w++) begin
                        if (evict_way[w]) begin
                            next_meta_out[w] = ST_PENDING;
                        end
                    end
                end
            end else if (l2_inv) begin
                if ($onehot(hit_way)) begin
                    for (int w = 0; w < `ICACHE_WAYS; w++) begin
                        if (hit_way[w]) begin
                            next_meta_out[w] = ST_INVALID;
                        end
                    end
                end
            end else if ($onehot(hit_way)) begin
                for (int w = 0; w < `ICACHE_WAYS; w++) begin
                    if (hit_way[w]) begin
                        next_meta_out[w] = next_state;
                    end
                end
            end
        end
    end

endmodule

/* icache/icache_way.sv */
`timescale 1ns/1ps
`include "icache_defs.svh"

module icache_way (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      rd_en,
    input  logic [`ICACHE_IDX_W-1:0]  idx,
    input  logic [`ICACHE_IDX_W-1:0]  wr_idx,
    input  logic                      wr_en,
    input  logic                      wr_set_present,
    input  logic [`ICACHE_TAG_W-1:0]  wr_tag,
    input  icache_pkg::line_state_t   wr_state,
    output logic [`ICACHE_TAG_W-1:0]  way_tag,
    output logic                      way_present,
    output icache_pkg::line_state_t   way_state
);
    import icache_pkg::*;

    logic [`ICACHE_TAG_W-1:0] tag_mem [`ICACHE_SETS];
    logic [`ICACHE_SETS-1:0]  present_mem;
    line_state_t              state_mem [`ICACHE_SETS];

    // Present bits and states come up cleared.
    always_ff @(posedge clk) begin
        if (rst) begin
            present_mem <= '0;
            for (int s = 0; s < `ICACHE_SETS; s++) begin
                state_mem[s] <= ST_INVALID;
            end
        end else if (wr_en) begin
            state_mem[wr_idx] <= wr_state;
            if (wr_set_present) begin
                present_mem[wr_idx] <= 1'b1;   // Allocation.
            end
        end
    end

    // Tag only loads on allocation.
    always_ff @(posedge clk) begin
        if (wr_en && wr_set_present) begin
            tag_mem[wr_idx] <= wr_tag;
        end
    end

    // One-cycle read.
    always_ff @(posedge clk) begin
        if (rd_en) begin
            way_tag     <= tag_mem[idx];
            way_present <= present_mem[idx];
            way_state   <= state_mem[idx];
        end
    end

endmodule

/* icache/icache_update.sv */
`timescale 1ns/1ps
`include "icache_defs.svh"

module icache_update (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      req_vld,
    input  logic                      is_write,
    input  logic [`ICACHE_IDX_W-1:0]  idx,
    input  logic [`ICACHE_TAG_W-1:0]  tag,
    input  icache_pkg::icache_cmd_t   cmd,
    input  logic [`ICACHE_TAG_W-1:0]  way_tag [`ICACHE_WAYS],
    input  logic [`ICACHE_WAYS-1:0]   way_present,
    input  icache_pkg::line_state_t   way_state [`ICACHE_WAYS],
    output icache_pkg::way_vec_t      wr_en,
    output logic                      wr_set_present,
    output logic [`ICACHE_IDX_W-1:0]  wr_idx,
    output logic [`ICACHE_TAG_W-1:0]  wr_tag,
    output icache_pkg::set_meta_t     wr_state_word,
    output logic                      rsp_vld,
    output logic [`WB_DAT_W-1:0]      rsp_data
);
    import icache_pkg::*;

    localparam int PAD_W = `WB_DAT_W - `ICACHE_WAYS - $bits(set_meta_t);

    set_meta_t                       cur_meta;
    set_meta_t                       next_meta;
    way_vec_t                        hit;
    way_vec_t                        victim;
    logic                            victim_free;
    logic [$clog2(`ICACHE_WAYS)-1:0] rr_ptr;
    logic                            upd_vld;
    logic                            do_evict;

    always_comb begin
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            cur_meta[w] = way_state[w];
            hit[w]      = way_present[w] && (way_tag[w] == tag);
        end
    end

    // Lowest free way, else round robin.
    always_comb begin
        victim      = '0;
        victim_free = 1'b0;
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            if (!way_present[w] && !victim_free) begin
                victim[w]   = 1'b1;
                victim_free = 1'b1;
            end
        end
        if (!victim_free) begin
            victim[rr_ptr] = 1'b1;
        end
    end

    assign upd_vld  = req_vld && is_write;
    assign do_evict = upd_vld && (cmd == CMD_EVICT);

    inext_state u_next (
        .valid_in      (upd_vld),
        .f2_meta_in    (cur_meta),
        .f2_ld         (cmd == CMD_FETCH),
        .l2_w          (cmd == CMD_FILL),
        .l2_inv        (cmd == CMD_INV),
        .f2_evict      (cmd == CMD_EVICT),
        .hit_way       (hit),
        .evict_way     (victim),
        .next_meta_out (next_meta)
    );

    // Evict always rewrites the victim, since its tag changes.
    always_comb begin
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            wr_en[w] = upd_vld && (do_evict ? victim[w] : (next_meta[w] != cur_meta[w]));
        end
    end

    assign wr_set_present = do_evict;
    assign wr_idx         = idx;
    assign wr_tag         = tag;
    assign wr_state_word  = next_meta;

    always_ff @(posedge clk) begin
        if (rst) begin
            rr_ptr  <= '0;
            rsp_vld <= 1'b0;
        end else begin
            rsp_vld <= req_vld;
            if (do_evict && !victim_free) begin
                rr_ptr <= rr_ptr + 1'b1;   // Full set only.
            end
        end
    end

    always_ff @(posedge clk) begin
        rsp_data <= is_write ? '0 : {{PAD_W{1'b0}}, hit, cur_meta};
    end

endmodule

/* rtl/icache_wb_front.sv */
`timescale 1ns/1ps
`include "icache_defs.svh"

module icache_wb_front (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       cyc,
    input  logic                       stb,
    input  logic                       we,
    input  logic [`ICACHE_ADDR_W-1:0]  adr,
    input  logic [`WB_DAT_W-1:0]       dat_w,
    output logic                       ack,
    output logic [`WB_DAT_W-1:0]       dat_r,
    output logic                       rd_en,
    output logic                       req_vld,
    output logic                       is_write,
    output logic [`ICACHE_IDX_W-1:0]   idx,
    output logic [`ICACHE_TAG_W-1:0]   tag,
    output icache_pkg::icache_cmd_t    cmd,
    input  logic                       rsp_vld,
    input  logic [`WB_DAT_W-1:0]       rsp_data
);
    import icache_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOOKUP,
        S_UPDATE,
        S_RESP,
        S_DONE
    } front_state_t;

    front_state_t state;
    logic         busy;
    logic         accept;

    assign busy   = (state != S_IDLE);
    assign accept = cyc && stb && !busy;

    // Sequencer, one request in flight.
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE: begin
                    if (accept) begin
                        state <= S_LOOKUP;
                    end
                end
                S_LOOKUP: state <= S_UPDATE;   // Ways read this cycle.
                S_UPDATE: state <= S_RESP;     // Update stage writes back.
                S_RESP: begin
                    if (rsp_vld) begin
                        state <= S_DONE;
                    end
                end
                // Host drops stb after ack; give it one cycle.
                S_DONE: state <= S_IDLE;
                default: state <= S_IDLE;
            endcase
        end
    end

    // Request capture and address split.
    always_ff @(posedge clk) begin
        if (accept) begin
            is_write <= we;
            idx      <= adr[`ICACHE_OFS_W +: `ICACHE_IDX_W];
            tag      <= adr[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W];
            cmd      <= icache_cmd_t'(dat_w[1:0]);   // Command field.
        end
    end

    assign rd_en   = (state == S_LOOKUP);
    assign req_vld = (state == S_UPDATE);

    assign ack   = (state == S_RESP) && rsp_vld && cyc && stb;
    assign dat_r = ack ? rsp_data : '0;

endmodule

/* rtl/icache_meta_top.sv */
`timescale 1ns/1ps
`include "icache_defs.svh"

module icache_meta_top (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      cyc,
    input  logic                      stb,
    input  logic                      we,
    input  logic [`ICACHE_ADDR_W-1:0] adr,
    input  logic [`WB_DAT_W-1:0]      dat_w,
    output logic                      ack,
    output logic [`WB_DAT_W-1:0]      dat_r
);
    import icache_pkg::*;

    logic                     rd_en;
    logic                     req_vld;
    logic                     is_write;
    logic [`ICACHE_IDX_W-1:0] idx;
    logic [`ICACHE_TAG_W-1:0] tag;
    icache_cmd_t              cmd;
    logic                     rsp_vld;
    logic [`WB_DAT_W-1:0]     rsp_data;

    logic [`ICACHE_TAG_W-1:0] way_tag [`ICACHE_WAYS];
    logic [`ICACHE_WAYS-1:0]  way_present;
    line_state_t              way_state [`ICACHE_WAYS];

    way_vec_t                 wr_en;
    logic                     wr_set_present;
    logic [`ICACHE_IDX_W-1:0] wr_idx;
    logic [`ICACHE_TAG_W-1:0] wr_tag;
    set_meta_t                wr_state_word;

    icache_wb_front u_front (
        .clk      (clk),
        .rst      (rst),
        .cyc      (cyc),
        .stb      (stb),
        .we       (we),
        .adr      (adr),
        .dat_w    (dat_w),
        .ack      (ack),
        .dat_r    (dat_r),
        .rd_en    (rd_en),
        .req_vld  (req_vld),
        .is_write (is_write),
        .idx      (idx),
        .tag      (tag),
        .cmd      (cmd),
        .rsp_vld  (rsp_vld),
        .rsp_data (rsp_data)
    );

    for (genvar i = 0; i < `ICACHE_WAYS; i++) begin : g_way
        icache_way u_way (
            .clk            (clk),
            .rst            (rst),
            .rd_en          (rd_en),
            .idx            (idx),
            .wr_idx         (wr_idx),
            .wr_en          (wr_en[i]),
            .wr_set_present (wr_set_present),
            .wr_tag         (wr_tag),
            .wr_state       (wr_state_word[i]),
            .way_tag        (way_tag[i]),
            .way_present    (way_present[i]),
            .way_state      (way_state[i])
        );
    end

    icache_update u_update (
        .clk            (clk),
        .rst            (rst),
        .req_vld        (req_vld),
        .is_write       (is_write),
        .idx            (idx),
        .tag            (tag),
        .cmd            (cmd),
        .way_tag        (way_tag),
        .way_present    (way_present),
        .way_state      (way_state),
        .wr_en          (wr_en),
        .wr_set_present (wr_set_present),
        .wr_idx         (wr_idx),
        .wr_tag         (wr_tag),
        .wr_state_word  (wr_state_word),
        .rsp_vld        (rsp_vld),
        .rsp_data       (rsp_data)
    );

endmodule

/* verification/icache_meta_chk.sv */
`timescale 1ns/1ps
`include "icache_defs.svh"

module icache_meta_chk (
    input logic                 clk,
    input logic                 rst,
    input logic                 cyc,
    input logic                 stb,
    input logic                 we,
    input logic                 ack,
    input logic [`WB_DAT_W-1:0] dat_r
);
    localparam int HIT_LSB = `ICACHE_WAYS * 5;   // Hit vector sits above the state word.

    logic strobe;
    int   n_fail = 0;

    assign strobe = cyc && stb;

    ack_one_cycle: assert property (@(posedge clk) disable iff (rst) ack |=> !ack)
        else begin
            n_fail++;
            $error("ack stayed high for more than one cycle");
        end

    ack_needs_strobe: assert property (@(posedge clk) disable iff (rst) ack |-> $past(strobe, 3))
        else begin
            n_fail++;
            $error("ack raised without a strobe three cycles earlier");
        end

    // Ack lands in T+3 when the strobe first rises in T.
    ack_latency: assert property (@(posedge clk) disable iff (rst) $rose(strobe) |-> ##3 ack)
        else begin
            n_fail++;
            $error("ack did not arrive 3 cycles after the strobe");
        end

    hit_onehot: assert property (@(posedge clk) disable iff (rst)
        (ack && !we) |-> $onehot0(dat_r[HIT_LSB +: `ICACHE_WAYS]))
        else begin
            n_fail++;
            $error("read hit vector has more than one way set");
        end

endmodule

/* verification/tb_icache_meta.sv */
`timescale 1ns/1ps
`include "icache_defs.svh"

module tb_icache_meta;
    import icache_pkg::*;

    localparam int N_RANDOM = 40;
    localparam int CLK_HALF = 10;

    // Line state codes.
    localparam logic [4:0] INV = 5'd0;
    localparam logic [4:0] PEN = 5'd2;
    localparam logic [4:0] VAL = 5'd16;

    localparam logic [`ICACHE_TAG_W-1:0] TAG_A    = 20'h000a0;
    localparam logic [`ICACHE_TAG_W-1:0] TAG_B    = 20'h000b1;
    localparam logic [`ICACHE_TAG_W-1:0] TAG_C    = 20'h000c2;
    localparam logic [`ICACHE_TAG_W-1:0] TAG_D    = 20'h000d3;
    localparam logic [`ICACHE_TAG_W-1:0] TAG_E    = 20'h000e4;
    localparam logic [`ICACHE_TAG_W-1:0] TAG_F    = 20'h000f5;
    localparam logic [`ICACHE_TAG_W-1:0] TAG_X    = 20'h00777;
    localparam logic [`ICACHE_TAG_W-1:0] TAG_BASE = 20'h00100;

    logic                      clk;
    logic                      rst;
    logic                      cyc;
    logic                      stb;
    logic                      we;
    logic [`ICACHE_ADDR_W-1:0] adr;
    logic [`WB_DAT_W-1:0]      dat_w;
    logic                      ack;
    logic [`WB_DAT_W-1:0]      dat_r;

    // Command table.
    logic                     tbl_read [$];
    icache_cmd_t              tbl_cmd [$];
    int                       tbl_set [$];
    logic [`ICACHE_TAG_W-1:0] tbl_tag [$];
    string                    tbl_name [$];
    logic [31:0]              tbl_exp [$];

    // Reference model of the metadata.
    logic [`ICACHE_TAG_W-1:0] m_tag [`ICACHE_SETS][`ICACHE_WAYS];
    logic                     m_present [`ICACHE_SETS][`ICACHE_WAYS];
    logic [4:0]               m_state [`ICACHE_SETS][`ICACHE_WAYS];
    int                       m_rr;

    int n_checks    = 0;
    int n_errors    = 0;
    int cycle_count = 0;
    int cycle_limit = 1000000;
    int seed        = 3832;

    icache_meta_top u_dut (
        .clk   (clk),
        .rst   (rst),
        .cyc   (cyc),
        .stb   (stb),
        .we    (we),
        .adr   (adr),
        .dat_w (dat_w),
        .ack   (ack),
        .dat_r (dat_r)
    );

    bind icache_meta_top icache_meta_chk u_chk (
        .clk   (clk),
        .rst   (rst),
        .cyc   (cyc),
        .stb   (stb),
        .we    (we),
        .ack   (ack),
        .dat_r (dat_r)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_HALF) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("=== FAIL ===");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        n_checks++;
        if (actual !== expected) begin
            n_errors++;
            $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    function automatic logic [`ICACHE_ADDR_W-1:0] make_addr(input logic [`ICACHE_TAG_W-1:0] t,
                                                            input int set);
        return {t, set[`ICACHE_IDX_W-1:0], {`ICACHE_OFS_W{1'b0}}};
    endfunction

    // Read word from a hit vector and the states of ways 3 down to 0.
    function automatic logic [31:0] meta_word(input logic [3:0] hit, input logic [4:0] s3,
                                              input logic [4:0] s2, input logic [4:0] s1,
                                              input logic [4:0] s0);
        return {8'h00, hit, s3, s2, s1, s0};
    endfunction

    task automatic model_reset();
        m_rr = 0;
        for (int s = 0; s < `ICACHE_SETS; s++) begin
            for (int w = 0; w < `ICACHE_WAYS; w++) begin
                m_tag[s][w]     = '0;
                m_present[s][w] = 1'b0;
                m_state[s][w]   = INV;
            end
        end
    endtask

    function automatic logic [3:0] model_hit(input int set, input logic [`ICACHE_TAG_W-1:0] t);
        logic [3:0] h;
        h = '0;
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            h[w] = m_present[set][w] && (m_tag[set][w] == t);
        end
        return h;
    endfunction

    function automatic logic [31:0] model_word(input int set, input logic [`ICACHE_TAG_W-1:0] t);
        return meta_word(model_hit(set, t), m_state[set][3], m_state[set][2],
                         m_state[set][1], m_state[set][0]);
    endfunction

    task automatic model_apply(input icache_cmd_t c, input int set,
                               input logic [`ICACHE_TAG_W-1:0] t);
        logic [3:0] h;
        int         way;
        int         victim;
        h   = model_hit(set, t);
        way = -1;
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            if (h[w] && $countones(h) == 1) begin
                way = w;
            end
        end
        case (c)
            CMD_EVICT: begin
                victim = -1;
                for (int w = `ICACHE_WAYS - 1; w >= 0; w--) begin
                    if (!m_present[set][w]) begin
                        victim = w;   // Lowest free way wins.
                    end
                end
                if (victim < 0) begin
                    victim = m_rr;
                    m_rr   = (m_rr + 1) % `ICACHE_WAYS;
                end
                m_tag[set][victim]     = t;
                m_present[set][victim] = 1'b1;
                m_state[set][victim]   = PEN;
            end
            CMD_INV: begin
                if (way >= 0) begin
                    m_state[set][way] = INV;
                end
            end
            CMD_FETCH: begin
                if (way >= 0 && m_state[set][way] == INV) begin
                    m_state[set][way] = PEN;
                end
            end
            default: begin
                if (way >= 0 && m_state[set][way] == PEN) begin
                    m_state[set][way] = VAL;
                end
            end
        endcase
    endtask

    task automatic push_command(input icache_cmd_t c, input int set,
                                input logic [`ICACHE_TAG_W-1:0] t, input string name);
        tbl_read.push_back(1'b0);
        tbl_cmd.push_back(c);
        tbl_set.push_back(set);
        tbl_tag.push_back(t);
        tbl_name.push_back(name);
        tbl_exp.push_back(32'd0);   // Writes answer with zero.
    endtask

    task automatic push_read(input int set, input logic [`ICACHE_TAG_W-1:0] t,
                             input string name, input logic [31:0] expected);
        tbl_read.push_back(1'b1);
        tbl_cmd.push_back(CMD_FETCH);
        tbl_set.push_back(set);
        tbl_tag.push_back(t);
        tbl_name.push_back(name);
        tbl_exp.push_back(expected);
    endtask

    task automatic build_table();
        push_read(0, TAG_A, "reset_read_set0", 32'd0);
        push_read(63, TAG_X, "reset_read_set63", 32'd0);
        push_read(5, TAG_A, "reset_read_set5", 32'd0);
        push_command(CMD_EVICT, 5, TAG_A, "evict_a");
        push_read(5, TAG_A, "evict_way0", meta_word(4'b0001, INV, INV, INV, PEN));
        push_command(CMD_EVICT, 5, TAG_B, "evict_b");
        push_read(5, TAG_B, "evict_way1", meta_word(4'b0010, INV, INV, PEN, PEN));
        push_command(CMD_EVICT, 5, TAG_C, "evict_c");
        push_read(5, TAG_C, "evict_way2", meta_word(4'b0100, INV, PEN, PEN, PEN));
        push_command(CMD_EVICT, 5, TAG_D, "evict_d");
        push_read(5, TAG_D, "evict_way3", meta_word(4'b1000, PEN, PEN, PEN, PEN));
        // Round robin from way 0 once the set is full.
        push_command(CMD_EVICT, 5, TAG_E, "evict_e");
        push_read(5, TAG_E, "evict_rr_way0", meta_word(4'b0001, PEN, PEN, PEN, PEN));
        push_read(5, TAG_A, "evicted_tag_gone", meta_word(4'b0000, PEN, PEN, PEN, PEN));
        push_command(CMD_EVICT, 5, TAG_F, "evict_f");
        push_read(5, TAG_F, "evict_rr_way1", meta_word(4'b0010, PEN, PEN, PEN, PEN));
        push_command(CMD_FILL, 5, TAG_C, "fill_c");
        push_read(5, TAG_C, "fill_pending", meta_word(4'b0100, PEN, VAL, PEN, PEN));
        push_command(CMD_FETCH, 5, TAG_C, "fetch_c");
        push_read(5, TAG_C, "fetch_valid_holds", meta_word(4'b0100, PEN, VAL, PEN, PEN));
        push_command(CMD_FETCH, 5, TAG_D, "fetch_d");
        push_read(5, TAG_D, "fetch_pending_holds", meta_word(4'b1000, PEN, VAL, PEN, PEN));
        push_command(CMD_FILL, 5, TAG_C, "refill_c");
        push_read(5, TAG_C, "fill_valid_holds", meta_word(4'b0100, PEN, VAL, PEN, PEN));
        push_command(CMD_INV, 5, TAG_E, "inv_e");
        push_read(5, TAG_E, "inv_hit_way", meta_word(4'b0001, PEN, VAL, PEN, INV));
        push_command(CMD_FETCH, 5, TAG_E, "fetch_e");
        push_read(5, TAG_E, "fetch_after_inv", meta_word(4'b0001, PEN, VAL, PEN, PEN));
        push_command(CMD_INV, 5, TAG_F, "inv_f");
        push_command(CMD_FILL, 5, TAG_F, "fill_f");
        push_read(5, TAG_F, "fill_invalid_holds", meta_word(4'b0010, PEN, VAL, INV, PEN));
        push_command(CMD_FETCH, 5, TAG_X, "fetch_absent");
        push_command(CMD_FILL, 5, TAG_X, "fill_absent");
        push_command(CMD_INV, 5, TAG_X, "inv_absent");
        push_read(5, TAG_X, "absent_tag", meta_word(4'b0000, PEN, VAL, INV, PEN));
        push_command(CMD_EVICT, 6, TAG_A, "evict_a_set6");
        push_command(CMD_FILL, 6, TAG_A, "fill_a_set6");
        push_read(5, TAG_C, "other_set_isolated", meta_word(4'b0100, PEN, VAL, INV, PEN));
        push_read(6, TAG_A, "other_set_alloc", meta_word(4'b0001, INV, INV, INV, VAL));
    endtask

    // One Wishbone classic cycle; ack and data are sampled on the falling edge.
    task automatic wb_transfer(input logic write, input logic [`ICACHE_ADDR_W-1:0] addr,
                               input logic [`WB_DAT_W-1:0] wdata,
                               output logic [`WB_DAT_W-1:0] rdata,
                               output int latency, output logic ack_after);
        latency = 0;
        @(posedge clk);
        cyc   <= 1'b1;
        stb   <= 1'b1;
        we    <= write;
        adr   <= addr;
        dat_w <= wdata;
        @(negedge clk);
        while (!ack) begin
            latency++;
            @(negedge clk);
        end
        rdata = dat_r;
        @(posedge clk);
        cyc   <= 1'b0;
        stb   <= 1'b0;
        we    <= 1'b0;
        @(negedge clk);
        ack_after = ack;
    endtask

    task automatic run_entry(input string name, input logic is_read, input icache_cmd_t c,
                             input int set, input logic [`ICACHE_TAG_W-1:0] t,
                             input logic [31:0] expected);
        logic [`WB_DAT_W-1:0] rdata;
        int                   latency;
        logic                 ack_after;
        wb_transfer(!is_read, make_addr(t, set), {30'd0, c}, rdata, latency, ack_after);
        check_value({name, " data"}, expected, rdata);
        check_value({name, " latency"}, 32'd3, 32'(latency));
        check_value({name, " ack width"}, 32'd0, {31'd0, ack_after});
        if (!is_read) begin
            model_apply(c, set, t);
        end
    endtask

    initial begin
        int                       op;
        int                       set;
        int                       tsel;
        logic                     rd;
        logic [`ICACHE_TAG_W-1:0] t;
        icache_cmd_t              c;
        logic [31:0]              expected;
        rst   = 1'b1;
        cyc   = 1'b0;
        stb   = 1'b0;
        we    = 1'b0;
        adr   = '0;
        dat_w = '0;
        model_reset();
        build_table();
        cycle_limit = (tbl_read.size() + N_RANDOM) * 6 + 50;
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        for (int i = 0; i < tbl_read.size(); i++) begin
            run_entry(tbl_name[i], tbl_read[i], tbl_cmd[i], tbl_set[i], tbl_tag[i], tbl_exp[i]);
        end

        // Random traffic over sets 10 and 11 with six tags.
        for (int n = 0; n < N_RANDOM; n++) begin
            op   = $unsigned($random(seed)) % 5;
            set  = 10 + $unsigned($random(seed)) % 2;
            tsel = $unsigned($random(seed)) % 6;
            t    = TAG_BASE + tsel[`ICACHE_TAG_W-1:0];
            c    = icache_cmd_t'(op[1:0]);
            rd   = (op == 4) || ((c == CMD_EVICT) && (model_hit(set, t) != 4'b0000));
            expected = rd ? model_word(set, t) : 32'd0;
            run_entry($sformatf("rand_%0d set %0d tag %h", n, set, t), rd, c, set, t, expected);
        end

        $display("Checks: %0d, errors: %0d, assertion failures: %0d",
                 n_checks, n_errors, u_dut.u_chk.n_fail);
        if (n_errors == 0 && u_dut.u_chk.n_fail == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* sources.f */
+incdir+common
common/icache_pkg.sv
icache/inext_state.sv
icache/icache_way.sv
icache/icache_update.sv
rtl/icache_wb_front.sv
rtl/icache_meta_top.sv
verification/icache_meta_chk.sv
verification/tb_icache_meta.sv

/* Makefile */
# Verilator build for the instruction cache metadata testbench.
# Any variable can be overridden on the command line, e.g. make run OBJ_DIR=build

VERILATOR ?= verilator
TOP       ?= tb_icache_meta
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= === PASS ===

SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The simulation output goes to the terminal and the pass line decides the status.
run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
